// File: alu_pkg.sv
package alu_pkg;

    // ----------------------------------------------------------------------
    // Widths
    // ----------------------------------------------------------------------
    localparam int XLEN    = 32;
    localparam int SHAMT_W = $clog2(XLEN);

    // LDPC lanes, one signed message per byte
    localparam int LANE_W       = 8;
    localparam int NUM_LANES    = XLEN / LANE_W;
    // Symmetric bound, -128 never comes out of the saturating ops
    localparam int LANE_SAT_MAX = 127;

    // Issue stage FSM encoding
    localparam logic [1:0] ISSUE_EMPTY    = 2'd0;
    localparam logic [1:0] ISSUE_HOLDING  = 2'd1;
    localparam logic [1:0] ISSUE_DRAINING = 2'd2;

    // ----------------------------------------------------------------------
    // Data types
    // ----------------------------------------------------------------------
    typedef logic [XLEN-1:0]          xlen_t;
    typedef logic signed [LANE_W-1:0] lane_t;

    typedef enum logic [4:0] {
        // Adder
        ADD,
        SUB,
        // Logic, the N forms take the inverted b
        ANDL,
        ORL,
        XORL,
        ANDN,
        ORN,
        XNOR,
        // Shifts
        SLL,
        SRL,
        SRA,
        // Set less than
        SLTS,
        SLTU,
        // Branch conditions
        EQ,
        NE,
        LTS,
        LTU,
        GES,
        GEU,
        // LDPC lane operations
        LDPC_MIN,
        LDPC_ABS,
        LDPC_ADD_SAT,
        LDPC_SUB_SAT,
        LDPC_MINMAX,
        LDPC_MIN_SORTING,
        LDPC_RSIGN_NMESS
    } alu_op_e;

    // Operand word, read whole by the integer unit or per lane by the LDPC unit
    typedef union packed {
        xlen_t                 word;
        lane_t [NUM_LANES-1:0] lanes;
    } alu_word_u;

endpackage

// File: alu_int_unit.sv
module alu_int_unit (
    input  alu_pkg::alu_op_e op_i,
    input  alu_pkg::xlen_t   operand_a_i,
    input  alu_pkg::xlen_t   operand_b_i,
    output alu_pkg::xlen_t   result_o,
    output logic             branch_res_o
);
    import alu_pkg::*;

    logic  negate_b;
    xlen_t operand_b_neg;
    xlen_t adder_result;
    logic  adder_zero;
    logic  shift_left;
    logic  shift_arith;
    xlen_t operand_a_rev;
    xlen_t shift_op_a;
    xlen_t shift_right_result;
    xlen_t shift_left_result;
    logic  signed_cmp;
    logic  less;

    // ----------------------------------------------------------------------
    // Adder
    // ----------------------------------------------------------------------
    always_comb begin
        unique case (op_i)
            SUB, EQ, NE, ANDN, ORN, XNOR: negate_b = 1'b1;
            default:                      negate_b = 1'b0;
        endcase
    end

    // Inverted b is shared with the negated logic ops
    assign operand_b_neg = operand_b_i ^ {XLEN{negate_b}};
    assign adder_result  = operand_a_i + operand_b_neg + xlen_t'(negate_b);
    assign adder_zero    = ~|adder_result;

    // ----------------------------------------------------------------------
    // Shifter
    // ----------------------------------------------------------------------
    assign shift_left  = (op_i == SLL);
    assign shift_arith = (op_i == SRA);

    // Left shift is a right shift of the reversed word
    for (genvar k = 0; k < XLEN; k++) begin : gen_rev
        assign operand_a_rev[k]     = operand_a_i[XLEN-1-k];
        assign shift_left_result[k] = shift_right_result[XLEN-1-k];
    end

    assign shift_op_a = shift_left ? operand_a_rev : operand_a_i;

    // Fill bit is the sign only for SRA
    assign shift_right_result =
        xlen_t'($signed({shift_arith & shift_op_a[XLEN-1], shift_op_a})
                >>> operand_b_i[SHAMT_W-1:0]);

    // ----------------------------------------------------------------------
    // Comparator
    // ----------------------------------------------------------------------
    assign signed_cmp = (op_i == SLTS) | (op_i == LTS) | (op_i == GES);

    assign less = $signed({signed_cmp & operand_a_i[XLEN-1], operand_a_i}) <
                  $signed({signed_cmp & operand_b_i[XLEN-1], operand_b_i});

    always_comb begin
        unique case (op_i)
            EQ:       branch_res_o = adder_zero;
            NE:       branch_res_o = ~adder_zero;
            LTS, LTU: branch_res_o = less;
            GES, GEU: branch_res_o = ~less;
            default:  branch_res_o = 1'b1;
        endcase
    end

    // Result select, branch and LDPC ops give zero here
    always_comb begin
        unique case (op_i)
            ANDL, ANDN: result_o = operand_a_i & operand_b_neg;
            ORL, ORN:   result_o = operand_a_i | operand_b_neg;
            XORL, XNOR: result_o = operand_a_i ^ operand_b_neg;
            ADD, SUB:   result_o = adder_result;
            SLL:        result_o = shift_left_result;
            SRL, SRA:   result_o = shift_right_result;
            SLTS, SLTU: result_o = {{(XLEN-1){1'b0}}, less};
            default:    result_o = '0;
        endcase
    end

endmodule

// File: alu_ldpc_unit.sv
module alu_ldpc_unit (
    input  alu_pkg::alu_op_e   op_i,
    input  alu_pkg::alu_word_u operand_a_i,
    input  alu_pkg::alu_word_u operand_b_i,
    input  alu_pkg::alu_word_u imm_i,
    output alu_pkg::xlen_t     result_o
);
    import alu_pkg::*;

    lane_t [NUM_LANES-1:0] r_min;
    lane_t [NUM_LANES-1:0] r_abs;
    lane_t [NUM_LANES-1:0] r_add_sat;
    lane_t [NUM_LANES-1:0] r_sub_sat;
    lane_t [NUM_LANES-1:0] r_minmax;
    lane_t [NUM_LANES-1:0] r_min_sort;
    lane_t [NUM_LANES-1:0] r_rsign;

    // Clamp a 9-bit lane result to +-LANE_SAT_MAX
    function automatic lane_t sat_lane(input logic signed [LANE_W:0] value);
        lane_t res;
        if (value > LANE_SAT_MAX) begin
            res = lane_t'(LANE_SAT_MAX);
        end else if (value < -LANE_SAT_MAX) begin
            res = lane_t'(-LANE_SAT_MAX);
        end else begin
            res = value[LANE_W-1:0];
        end
        return res;
    endfunction

    // ----------------------------------------------------------------------
    // Per lane arithmetic
    // ----------------------------------------------------------------------
    for (genvar i = 0; i < NUM_LANES; i++) begin : gen_lane
        lane_t                  a_l;
        lane_t                  b_l;
        lane_t                  imm_l;
        lane_t                  lane_max;
        lane_t                  a_pos;
        lane_t                  rsign_eval;
        logic signed [LANE_W:0] sum;
        logic signed [LANE_W:0] diff;
        logic                   a_ge_b;

        assign a_l   = operand_a_i.lanes[i];
        assign b_l   = operand_b_i.lanes[i];
        assign imm_l = imm_i.lanes[i];

        // One extra bit so the overflow is visible before clamping
        assign sum          = a_l + b_l;
        assign diff         = a_l - b_l;
        assign r_add_sat[i] = sat_lane(sum);
        assign r_sub_sat[i] = sat_lane(diff);

        assign a_ge_b   = (a_l >= b_l);
        assign lane_max = a_ge_b ? a_l : b_l;
        assign r_min[i] = a_ge_b ? b_l : a_l;

        // -128 wraps back to 0x80
        assign r_abs[i] = (a_l >= 0) ? a_l : -a_l;

        assign r_minmax[i]   = (imm_l >= lane_max) ? lane_max : imm_l;
        assign r_min_sort[i] = (a_l == b_l) ? imm_l : a_l;

        // Flip bit 0 of b when a is non-negative
        assign a_pos      = (a_l >= 0) ? lane_t'(1) : lane_t'(0);
        assign rsign_eval = b_l ^ a_pos;
        assign r_rsign[i] = (rsign_eval != 0) ? imm_l : -imm_l;
    end

    always_comb begin
        unique case (op_i)
            LDPC_MIN:         result_o = r_min;
            LDPC_ABS:         result_o = r_abs;
            LDPC_ADD_SAT:     result_o = r_add_sat;
            LDPC_SUB_SAT:     result_o = r_sub_sat;
            LDPC_MINMAX:      result_o = r_minmax;
            LDPC_MIN_SORTING: result_o = r_min_sort;
            LDPC_RSIGN_NMESS: result_o = r_rsign;
            default:          result_o = '0;
        endcase
    end

endmodule

// File: alu_issue_stage.sv
module alu_issue_stage (
    input  logic               clk_i,
    input  logic               arst_n_i,
    // Request side
    input  logic               req_i,
    output logic               ack_o,
    input  alu_pkg::alu_op_e   op_i,
    input  alu_pkg::alu_word_u operand_a_i,
    input  alu_pkg::alu_word_u operand_b_i,
    input  alu_pkg::alu_word_u imm_i,
    // Towards the execute stage
    output logic               exec_req_o,
    input  logic               exec_ack_i,
    output alu_pkg::alu_op_e   op_o,
    output alu_pkg::alu_word_u operand_a_o,
    output alu_pkg::alu_word_u operand_b_o,
    output alu_pkg::alu_word_u imm_o
);
    import alu_pkg::*;

    logic [1:0] state_q;
    logic [1:0] state_d;
    logic       capture;

    // Room for a new item, also in the cycle the last hand-over ends
    assign capture = req_i & ~ack_o &
                     ((state_q == ISSUE_EMPTY) |
                      ((state_q == ISSUE_DRAINING) & ~exec_ack_i));

    // ----------------------------------------------------------------------
    // Hand-over FSM
    // ----------------------------------------------------------------------
    always_comb begin
        state_d = state_q;
        unique case (state_q)
            ISSUE_EMPTY: begin
                if (capture) begin
                    state_d = ISSUE_HOLDING;
                end
            end
            ISSUE_HOLDING: begin
                if (exec_ack_i) begin
                    state_d = ISSUE_DRAINING;
                end
            end
            ISSUE_DRAINING: begin
                if (!exec_ack_i) begin
                    state_d = capture ? ISSUE_HOLDING : ISSUE_EMPTY;
                end
            end
            default: state_d = ISSUE_EMPTY;
        endcase
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= ISSUE_EMPTY;
            ack_o   <= 1'b0;
        end else begin
            state_q <= state_d;
            if (capture) begin
                ack_o <= 1'b1;
            end else if (ack_o && !req_i) begin
                ack_o <= 1'b0;
            end
        end
    end

    assign exec_req_o = (state_q == ISSUE_HOLDING);

    // Operation held until the execute stage takes it
    always_ff @(posedge clk_i) begin
        if (capture) begin
            op_o        <= op_i;
            operand_a_o <= operand_a_i;
            operand_b_o <= operand_b_i;
            imm_o       <= imm_i;
        end
    end

endmodule

// File: alu_execute_stage.sv
module alu_execute_stage (
    input  logic               clk_i,
    input  logic               arst_n_i,
    // From the issue stage
    input  logic               exec_req_i,
    output logic               exec_ack_o,
    input  alu_pkg::alu_op_e   op_i,
    input  alu_pkg::alu_word_u operand_a_i,
    input  alu_pkg::alu_word_u operand_b_i,
    input  alu_pkg::alu_word_u imm_i,
    // Result side
    output logic               req_o,
    input  logic               ack_i,
    output alu_pkg::xlen_t     result_o,
    output logic               branch_res_o
);
    import alu_pkg::*;

    xlen_t int_result;
    logic  int_branch;
    xlen_t ldpc_result;
    logic  is_ldpc;
    logic  fire;

    alu_int_unit u_int_unit (
        .op_i         (op_i),
        .operand_a_i  (operand_a_i.word),
        .operand_b_i  (operand_b_i.word),
        .result_o     (int_result),
        .branch_res_o (int_branch)
    );

    alu_ldpc_unit u_ldpc_unit (
        .op_i        (op_i),
        .operand_a_i (operand_a_i),
        .operand_b_i (operand_b_i),
        .imm_i       (imm_i),
        .result_o    (ldpc_result)
    );

    always_comb begin
        unique case (op_i)
            LDPC_MIN, LDPC_ABS, LDPC_ADD_SAT, LDPC_SUB_SAT,
            LDPC_MINMAX, LDPC_MIN_SORTING, LDPC_RSIGN_NMESS: is_ldpc = 1'b1;
            default:                                         is_ldpc = 1'b0;
        endcase
    end

    // ----------------------------------------------------------------------
    // Handshakes
    // ----------------------------------------------------------------------
    // Output side is free only after ack_i has been seen low again
    assign fire = exec_req_i & ~exec_ack_o & ~req_o & ~ack_i;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            exec_ack_o <= 1'b0;
            req_o      <= 1'b0;
        end else begin
            if (fire) begin
                exec_ack_o <= 1'b1;
            end else if (exec_ack_o && !exec_req_i) begin
                exec_ack_o <= 1'b0;
            end
            if (fire) begin
                req_o <= 1'b1;
            end else if (req_o && ack_i) begin
                req_o <= 1'b0;
            end
        end
    end

    // Held stable while req_o is up
    always_ff @(posedge clk_i) begin
        if (fire) begin
            result_o     <= is_ldpc ? ldpc_result : int_result;
            branch_res_o <= int_branch;
        end
    end

endmodule

// File: alu_top.sv
module alu_top (
    input  logic               clk_i,
    input  logic               arst_n_i,
    input  logic               req_i,
    output logic               ack_o,
    input  alu_pkg::alu_op_e   op_i,
    input  alu_pkg::alu_word_u operand_a_i,
    input  alu_pkg::alu_word_u operand_b_i,
    input  alu_pkg::alu_word_u imm_i,
    output logic               req_o,
    input  logic               ack_i,
    output alu_pkg::xlen_t     result_o,
    output logic               branch_res_o
);
    import alu_pkg::*;

    // Issue to execute link
    logic      exec_req;
    logic      exec_ack;
    alu_op_e   op;
    alu_word_u operand_a;
    alu_word_u operand_b;
    alu_word_u imm;

    alu_issue_stage u_issue (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .req_i       (req_i),
        .ack_o       (ack_o),
        .op_i        (op_i),
        .operand_a_i (operand_a_i),
        .operand_b_i (operand_b_i),
        .imm_i       (imm_i),
        .exec_req_o  (exec_req),
        .exec_ack_i  (exec_ack),
        .op_o        (op),
        .operand_a_o (operand_a),
        .operand_b_o (operand_b),
        .imm_o       (imm)
    );

    alu_execute_stage u_execute (
        .clk_i        (clk_i),
        .arst_n_i     (arst_n_i),
        .exec_req_i   (exec_req),
        .exec_ack_o   (exec_ack),
        .op_i         (op),
        .operand_a_i  (operand_a),
        .operand_b_i  (operand_b),
        .imm_i        (imm),
        .req_o        (req_o),
        .ack_i        (ack_i),
        .result_o     (result_o),
        .branch_res_o (branch_res_o)
    );

endmodule

// File: alu_checker.sv
module alu_checker (
    input  logic           clk_i,
    input  logic           arst_n_i,
    // DUT handshake lines being watched
    input  logic           in_ack_i,
    input  logic           out_req_i,
    input  alu_pkg::xlen_t result_i,
    input  logic           branch_i,
    // Expected values from the stimulus loop
    input  logic           exp_valid_i,
    input  alu_pkg::xlen_t exp_result_i,
    input  logic           exp_branch_i,
    output int             pass_count_o,
    output int             fail_count_o,
    output int             done_count_o
);
    import alu_pkg::*;

    xlen_t exp_result_q[$];
    logic  exp_branch_q[$];
    logic  in_ack_d;
    logic  out_req_d;
    logic  reset_seen;
    int    in_flight;
    int    passes;
    int    fails;
    int    num_done;
    xlen_t want_result;
    logic  want_branch;
    logic  ok;

    initial begin
        in_ack_d   = 1'b0;
        out_req_d  = 1'b0;
        reset_seen = 1'b0;
        in_flight  = 0;
        passes     = 0;
        fails      = 0;
        num_done   = 0;
    end

    assign pass_count_o = passes;
    assign fail_count_o = fails;
    assign done_count_o = num_done;

    always @(posedge clk_i) begin
        if (arst_n_i) begin
            // First edge out of reset, before any request
            if (!reset_seen) begin
                reset_seen = 1'b1;
                if (in_ack_i !== 1'b0 || out_req_i !== 1'b0) begin
                    $display("reset test failed: ack_o or req_o not low after reset");
                    fails++;
                end else begin
                    $display("reset test ok");
                    passes++;
                end
            end

            if (exp_valid_i) begin
                exp_result_q.push_back(exp_result_i);
                exp_branch_q.push_back(exp_branch_i);
            end

            // At most two items may sit inside the pipeline
            if (in_ack_i && !in_ack_d) begin
                if (in_flight >= 2) begin
                    $display("ack_o rose at %0t while both stages already held items", $time);
                    fails++;
                end
                in_flight++;
            end
            if (!out_req_i && out_req_d) begin
                in_flight--;
            end

            // ------------------------------------------------------------------
            // Result compare on each rise of req_o
            // ------------------------------------------------------------------
            if (out_req_i && !out_req_d) begin
                if (exp_result_q.size() == 0) begin
                    $display("a result arrived at %0t but no test was waiting for one", $time);
                    fails++;
                end else begin
                    want_result = exp_result_q.pop_front();
                    want_branch = exp_branch_q.pop_front();
                    ok = 1'b1;
                    if (result_i !== want_result) begin
                        $display("error at %0t: result_o expected %h got %h",
                                 $time, want_result, result_i);
                        ok = 1'b0;
                    end
                    if (branch_i !== want_branch) begin
                        $display("error at %0t: branch_res_o expected %b got %b",
                                 $time, want_branch, branch_i);
                        ok = 1'b0;
                    end
                    if (ok) begin
                        passes++;
                        $display("test %0d ok", num_done);
                    end else begin
                        fails++;
                        $display("test %0d failed", num_done);
                    end
                    num_done++;
                end
            end

            in_ack_d  = in_ack_i;
            out_req_d = out_req_i;
        end
    end

endmodule

// File: tb_alu_top.sv
module tb_alu_top;
    import alu_pkg::*;

    localparam int          CYCLES_PER_TEST = 40;
    localparam logic [31:0] LFSR_SEED       = 32'h14934a38;

    logic      clk_i;
    logic      arst_n_i;
    logic      req_i;
    logic      ack_o;
    alu_op_e   op_i;
    alu_word_u operand_a_i;
    alu_word_u operand_b_i;
    alu_word_u imm_i;
    logic      req_o;
    logic      ack_i;
    xlen_t     result_o;
    logic      branch_res_o;

    logic  exp_valid;
    xlen_t exp_result;
    logic  exp_branch;
    int    pass_count;
    int    fail_count;
    int    done_count;
    logic [31:0] lfsr;

    // Stimulus table with one entry per test
    alu_op_e tbl_op[$];
    xlen_t   tbl_a[$];
    xlen_t   tbl_b[$];
    xlen_t   tbl_imm[$];
    xlen_t   tbl_res[$];
    logic    tbl_br[$];

    alu_top u_dut (
        .clk_i        (clk_i),
        .arst_n_i     (arst_n_i),
        .req_i        (req_i),
        .ack_o        (ack_o),
        .op_i         (op_i),
        .operand_a_i  (operand_a_i),
        .operand_b_i  (operand_b_i),
        .imm_i        (imm_i),
        .req_o        (req_o),
        .ack_i        (ack_i),
        .result_o     (result_o),
        .branch_res_o (branch_res_o)
    );

    alu_checker u_checker (
        .clk_i        (clk_i),
        .arst_n_i     (arst_n_i),
        .in_ack_i     (ack_o),
        .out_req_i    (req_o),
        .result_i     (result_o),
        .branch_i     (branch_res_o),
        .exp_valid_i  (exp_valid),
        .exp_result_i (exp_result),
        .exp_branch_i (exp_branch),
        .pass_count_o (pass_count),
        .fail_count_o (fail_count),
        .done_count_o (done_count)
    );

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    // Galois step for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        return state[0] ? ((state >> 1) ^ 32'h80200003) : (state >> 1);
    endfunction

    task automatic draw_ack_delay(output int delay);
        logic [2:0] bits;
        bits = '0;
        for (int k = 0; k < 3; k++) begin
            lfsr = lfsr_step(lfsr);
            bits = {bits[1:0], lfsr[0]};
        end
        delay = int'(bits);
    endtask

    task automatic add_test(input alu_op_e op, input xlen_t a, input xlen_t b,
                            input xlen_t imm, input xlen_t res, input logic br);
        tbl_op.push_back(op);
        tbl_a.push_back(a);
        tbl_b.push_back(b);
        tbl_imm.push_back(imm);
        tbl_res.push_back(res);
        tbl_br.push_back(br);
    endtask

    // Full four-phase transaction on the input side
    task automatic send_item(input int idx);
        @(posedge clk_i);
        op_i             <= tbl_op[idx];
        operand_a_i.word <= tbl_a[idx];
        operand_b_i.word <= tbl_b[idx];
        imm_i.word       <= tbl_imm[idx];
        exp_result       <= tbl_res[idx];
        exp_branch       <= tbl_br[idx];
        exp_valid        <= 1'b1;
        req_i            <= 1'b1;
        @(posedge clk_i);
        exp_valid <= 1'b0;
        while (!ack_o) @(posedge clk_i);
        req_i <= 1'b0;
        @(posedge clk_i);
        while (ack_o) @(posedge clk_i);
    endtask

    // ----------------------------------------------------------------------
    // Main sequence
    // ----------------------------------------------------------------------
    initial begin
        arst_n_i         = 1'b0;
        req_i            = 1'b0;
        op_i             = ADD;
        operand_a_i.word = '0;
        operand_b_i.word = '0;
        imm_i.word       = '0;
        exp_valid        = 1'b0;
        exp_result       = '0;
        exp_branch       = 1'b0;

        // Adder and logic
        add_test(ADD,  32'h7fffffff, 32'h00000001, 32'hdeadbeef, 32'h80000000, 1'b1);
        add_test(ADD,  32'hffffffff, 32'h00000002, 32'h0, 32'h00000001, 1'b1);
        add_test(SUB,  32'h00000000, 32'h00000001, 32'h0, 32'hffffffff, 1'b1);
        add_test(SUB,  32'h12345678, 32'h02040608, 32'h0, 32'h10305070, 1'b1);
        add_test(ANDL, 32'hf0f0ff00, 32'h3c3c0ff0, 32'h0, 32'h30300f00, 1'b1);
        add_test(ORL,  32'hf0f0ff00, 32'h3c3c0ff0, 32'h0, 32'hfcfcfff0, 1'b1);
        add_test(XORL, 32'hf0f0ff00, 32'h3c3c0ff0, 32'h0, 32'hccccf0f0, 1'b1);
        add_test(ANDN, 32'hf0f0ff00, 32'h3c3c0ff0, 32'h0, 32'hc0c0f000, 1'b1);
        add_test(ORN,  32'hf0f0ff00, 32'h3c3c0ff0, 32'h0, 32'hf3f3ff0f, 1'b1);
        add_test(XNOR, 32'hf0f0ff00, 32'h3c3c0ff0, 32'h0, 32'h33330f0f, 1'b1);
        add_test(SLTS, 32'hffffffff, 32'h00000001, 32'h0, 32'h00000001, 1'b1);
        add_test(SLTU, 32'hffffffff, 32'h00000001, 32'h0, 32'h00000000, 1'b1);
        // Shifts ignore the upper bits of b
        add_test(SLL,  32'h12345678, 32'hffffffe4, 32'h0, 32'h23456780, 1'b1);
        add_test(SRL,  32'h80000010, 32'h00000004, 32'h0, 32'h08000001, 1'b1);
        add_test(SRA,  32'h80000010, 32'h00000004, 32'h0, 32'hf8000001, 1'b1);
        add_test(SRA,  32'h7ffffff0, 32'h00000020, 32'h0, 32'h7ffffff0, 1'b1);
        add_test(SRL,  32'h80000000, 32'h0000001f, 32'h0, 32'h00000001, 1'b1);
        // Branch conditions
        add_test(EQ,   32'h0000abcd, 32'h0000abcd, 32'h0, 32'h0, 1'b1);
        add_test(EQ,   32'h8000abcd, 32'h0000abcd, 32'h0, 32'h0, 1'b0);
        add_test(NE,   32'h8000abcd, 32'h0000abcd, 32'h0, 32'h0, 1'b1);
        add_test(NE,   32'h0000abcd, 32'h0000abcd, 32'h0, 32'h0, 1'b0);
        add_test(LTS,  32'h80000000, 32'h00000000, 32'h0, 32'h0, 1'b1);
        add_test(LTU,  32'h80000000, 32'h00000000, 32'h0, 32'h0, 1'b0);
        add_test(GES,  32'h80000000, 32'h00000000, 32'h0, 32'h0, 1'b0);
        add_test(GEU,  32'h80000000, 32'h00000000, 32'h0, 32'h0, 1'b1);
        add_test(GEU,  32'h00000000, 32'h80000000, 32'h0, 32'h0, 1'b0);
        // LDPC lanes with mixed values per word
        add_test(LDPC_ADD_SAT, 32'h70901081, 32'h20e005ff, 32'h0, 32'h7f811581, 1'b1);
        add_test(LDPC_SUB_SAT, 32'h7f800a00, 32'hff011480, 32'h0, 32'h7f81f67f, 1'b1);
        add_test(LDPC_MIN,     32'h05fb807f, 32'h03027f80, 32'h0, 32'h03fb8080, 1'b1);
        add_test(LDPC_ABS,     32'h80ff7fc3, 32'h00000000, 32'h0, 32'h80017f3d, 1'b1);
        add_test(LDPC_MINMAX,  32'h10f05080, 32'h20e03090, 32'h187f4085, 32'h18f04085, 1'b1);
        add_test(LDPC_MIN_SORTING, 32'h1122807f, 32'h1123807e, 32'haabbccdd,
                 32'haa22cc7f, 1'b1);
        add_test(LDPC_RSIGN_NMESS, 32'h050585ff, 32'h01000001, 32'h10207f33,
                 32'hf0208133, 1'b1);

        repeat (10) @(posedge clk_i);
        arst_n_i <= 1'b1;
        repeat (3) @(posedge clk_i);

        for (int i = 0; i < tbl_op.size(); i++) begin
            send_item(i);
        end
        while (done_count < tbl_op.size()) @(posedge clk_i);
        repeat (5) @(posedge clk_i);

        $display("summary: %0d passed, %0d failed", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    // Output side with random ack delay
    initial begin
        int delay;
        ack_i = 1'b0;
        lfsr  = LFSR_SEED;
        forever begin
            @(posedge clk_i);
            if (req_o) begin
                draw_ack_delay(delay);
                repeat (delay) @(posedge clk_i);
                ack_i <= 1'b1;
                @(posedge clk_i);
                while (req_o) @(posedge clk_i);
                ack_i <= 1'b0;
            end
        end
    end

    // Watchdog
    initial begin
        @(posedge arst_n_i);
        repeat (tbl_op.size() * CYCLES_PER_TEST) @(posedge clk_i);
        $display("timeout: only %0d of %0d results arrived in time", done_count, tbl_op.size());
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

// File: alu_top.f
alu_pkg.sv
alu_int_unit.sv
alu_ldpc_unit.sv
alu_issue_stage.sv
alu_execute_stage.sv
alu_top.sv
alu_checker.sv
tb_alu_top.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing
TOP       ?= tb_alu_top
FILELIST  ?= alu_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := NO ERRORS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
